/* design/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// address split: tag | index | offset
`define CACHE_ADDR_W    24
`define CACHE_OFFSET_W  2   // byte within the line
`define CACHE_INDEX_W   4   // 16 sets
`define CACHE_TAG_W     18

// line and way geometry
`define CACHE_LINE_W    32  // four bytes
`define CACHE_WAYS      4
`define CACHE_WAY_W     2

// least-used replacement
`define CACHE_USE_W     3   // saturates at 7

`endif

/* design/addr_pkg.sv */
`include "cache_consts.svh"

package addr_pkg;

  // one cpu or memory address, flat or split into its fields
  typedef union packed {
    logic [`CACHE_ADDR_W-1:0] word;
    struct packed {
      logic [`CACHE_TAG_W-1:0]    tag;
      logic [`CACHE_INDEX_W-1:0]  index;
      logic [`CACHE_OFFSET_W-1:0] offset;
    } f;
  } cache_addr_u;

endpackage

/* design/line_pkg.sv */
`include "cache_consts.svh"

package line_pkg;

  // one cache line, as the memory word or as its bytes
  typedef union packed {
    logic [`CACHE_LINE_W-1:0]         word;
    logic [(`CACHE_LINE_W/8)-1:0][7:0] bytes;  // byte 0 at bits 7:0
  } cache_line_u;

endpackage

/* design/array_ifs.sv */
`include "cache_consts.svh"

interface tag_if;
  logic [`CACHE_INDEX_W-1:0] index;
  logic [`CACHE_TAG_W-1:0]   tag;
  logic                      wr_en;      // install tag as valid and clean
  logic [`CACHE_WAY_W-1:0]   wr_way;
  logic                      set_dirty;
  logic                      hit;
  logic [`CACHE_WAY_W-1:0]   hit_way;
  logic [`CACHE_TAG_W-1:0]   way_tag;    // tag held in wr_way
  logic                      way_dirty;

  modport ctrl (output index, tag, wr_en, wr_way, set_dirty,
                input  hit, hit_way, way_tag, way_dirty);
  modport store (input  index, tag, wr_en, wr_way, set_dirty,
                 output hit, hit_way, way_tag, way_dirty);
endinterface

interface use_if;
  logic [`CACHE_INDEX_W-1:0] index;
  logic                      touch;
  logic                      fill;
  logic [`CACHE_WAY_W-1:0]   way;
  logic [`CACHE_WAY_W-1:0]   victim_way;

  modport ctrl (output index, touch, fill, way, input victim_way);
  modport store (input index, touch, fill, way, output victim_way);
endinterface

interface data_if;
  logic [`CACHE_INDEX_W-1:0]  index;
  logic [`CACHE_WAY_W-1:0]    way;
  logic [`CACHE_OFFSET_W-1:0] offset;
  logic                       byte_we;
  logic [7:0]                 wbyte;
  logic                       line_we;
  logic [`CACHE_LINE_W-1:0]   fill_line;
  logic [`CACHE_LINE_W-1:0]   rline;

  modport ctrl (output index, way, offset, byte_we, wbyte, line_we, fill_line,
                input  rline);
  modport store (input  index, way, offset, byte_we, wbyte, line_we, fill_line,
                 output rline);
endinterface

/* design/tag_store.sv */
`include "cache_consts.svh"

module tag_store (
  input logic  clk,
  input logic  reset,
  tag_if.store tag
);

  localparam int SETS = 1 << `CACHE_INDEX_W;

  logic [`CACHE_TAG_W-1:0]          tags_q [SETS][`CACHE_WAYS];
  logic [SETS-1:0][`CACHE_WAYS-1:0] valid_q;
  logic [SETS-1:0][`CACHE_WAYS-1:0] dirty_q;

  // compare against every way of the set
  always_comb begin
    tag.hit = 1'b0;
    tag.hit_way = '0;
    for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin  // lowest match wins
      if (valid_q[tag.index][w] && tags_q[tag.index][w] == tag.tag) begin
        tag.hit = 1'b1;
        tag.hit_way = `CACHE_WAY_W'(w);
      end
    end
  end

  assign tag.way_tag = tags_q[tag.index][tag.wr_way];
  assign tag.way_dirty = valid_q[tag.index][tag.wr_way] & dirty_q[tag.index][tag.wr_way];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (tag.wr_en) begin
      valid_q[tag.index][tag.wr_way] <= 1'b1;
      dirty_q[tag.index][tag.wr_way] <= 1'b0;  // fresh line from memory
    end else if (tag.set_dirty) begin
      dirty_q[tag.index][tag.wr_way] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.wr_en) begin
      tags_q[tag.index][tag.wr_way] <= tag.tag;
    end
  end

endmodule

/* design/use_counters.sv */
`include "cache_consts.svh"

module use_counters (
  input logic  clk,
  input logic  reset,
  use_if.store usage
);

  localparam int SETS = 1 << `CACHE_INDEX_W;

  logic [SETS-1:0][`CACHE_WAYS-1:0][`CACHE_USE_W-1:0] cnt_q;

  // two-level min tree over the four counts of the set
  always_comb begin
    logic [`CACHE_USE_W-1:0] c0, c1, c2, c3;
    logic [`CACHE_USE_W-1:0] min_lo, min_hi;
    logic                    pick_1, pick_3;
    c0 = cnt_q[usage.index][0];
    c1 = cnt_q[usage.index][1];
    c2 = cnt_q[usage.index][2];
    c3 = cnt_q[usage.index][3];
    pick_1 = c0 > c1;  // tie keeps way 0
    min_lo = pick_1 ? c1 : c0;
    pick_3 = c2 > c3;
    min_hi = pick_3 ? c3 : c2;
    usage.victim_way = {min_lo > min_hi, (min_lo <= min_hi) ? pick_1 : pick_3};
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cnt_q <= '0;  // every way invalid, so count 0
    end else if (usage.fill) begin
      cnt_q[usage.index][usage.way] <= `CACHE_USE_W'(1);
    end else if (usage.touch && cnt_q[usage.index][usage.way] != '1) begin
      cnt_q[usage.index][usage.way] <= cnt_q[usage.index][usage.way] + 1'b1;
    end
  end

endmodule

/* design/data_store.sv */
`include "cache_consts.svh"

module data_store (
  input logic   clk,
  data_if.store data
);

  localparam int SETS = 1 << `CACHE_INDEX_W;

  line_pkg::cache_line_u lines_q [SETS][`CACHE_WAYS];

  assign data.rline = lines_q[data.index][data.way].word;

  always_ff @(posedge clk) begin
    if (data.line_we) begin
      lines_q[data.index][data.way].word <= data.fill_line;
    end else if (data.byte_we) begin
      lines_q[data.index][data.way].bytes[data.offset] <= data.wbyte;
    end
  end

endmodule

/* design/cache_ctrl_fsm.sv */
`include "cache_consts.svh"

module cache_ctrl_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpu_req,
  input  logic                     cpu_we,
  input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
  input  logic [7:0]               cpu_wdata,
  output logic                     cpu_ack,
  output logic [7:0]               cpu_rdata,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [`CACHE_ADDR_W-1:0] mem_addr,
  output logic [`CACHE_LINE_W-1:0] mem_wdata,
  input  logic                     mem_ack,
  input  logic [`CACHE_LINE_W-1:0] mem_rdata,
  tag_if.ctrl                      tag,
  use_if.ctrl                      usage,
  data_if.ctrl                     data
);

  localparam logic [2:0] S_IDLE     = 3'd0;
  localparam logic [2:0] S_LOOKUP   = 3'd1;
  localparam logic [2:0] S_WB_REQ   = 3'd2;
  localparam logic [2:0] S_WB_REL   = 3'd3;
  localparam logic [2:0] S_FILL_REQ = 3'd4;
  localparam logic [2:0] S_FILL_REL = 3'd5;
  localparam logic [2:0] S_RESPOND  = 3'd6;
  localparam logic [2:0] S_RELEASE  = 3'd7;

  logic [2:0]              state;
  addr_pkg::cache_addr_u   addr_q;     // accepted cpu address
  logic [`CACHE_WAY_W-1:0] way_q;      // hit way or victim
  logic [`CACHE_WAY_W-1:0] cur_way;
  logic                    fill_done;
  addr_pkg::cache_addr_u   wb_addr;
  addr_pkg::cache_addr_u   fill_addr;
  line_pkg::cache_line_u   rline;

  // during lookup the way comes straight from the arrays
  assign cur_way = (state == S_LOOKUP) ? (tag.hit ? tag.hit_way : usage.victim_way) : way_q;
  assign fill_done = (state == S_FILL_REQ) && mem_ack;
  assign rline = data.rline;

  always_comb begin
    wb_addr.f.tag = tag.way_tag;
    wb_addr.f.index = addr_q.f.index;
    wb_addr.f.offset = '0;
    fill_addr = addr_q;
    fill_addr.f.offset = '0;  // lines are fetched aligned
  end

  assign tag.index = addr_q.f.index;
  assign tag.tag = addr_q.f.tag;
  assign tag.wr_way = cur_way;
  assign tag.wr_en = fill_done;
  assign tag.set_dirty = (state == S_RESPOND) && cpu_we;

  assign usage.index = addr_q.f.index;
  assign usage.way = cur_way;
  assign usage.touch = (state == S_LOOKUP) && tag.hit;
  assign usage.fill = fill_done;

  assign data.index = addr_q.f.index;
  assign data.way = cur_way;
  assign data.offset = addr_q.f.offset;
  assign data.byte_we = (state == S_RESPOND) && cpu_we;
  assign data.wbyte = cpu_wdata;
  assign data.line_we = fill_done;
  assign data.fill_line = mem_rdata;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
      cpu_ack <= 1'b0;
      mem_req <= 1'b0;
      mem_we <= 1'b0;
    end else begin
      case (state)
        S_IDLE: if (cpu_req) state <= S_LOOKUP;
        S_LOOKUP: begin
          if (tag.hit) begin
            state <= S_RESPOND;
          end else begin
            mem_req <= 1'b1;
            mem_we <= tag.way_dirty;  // dirty victim goes out first
            state <= tag.way_dirty ? S_WB_REQ : S_FILL_REQ;
          end
        end
        S_WB_REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state <= S_WB_REL;
          end
        end
        S_WB_REL: begin
          if (!mem_ack) begin
            mem_req <= 1'b1;
            mem_we <= 1'b0;
            state <= S_FILL_REQ;
          end
        end
        S_FILL_REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            state <= S_FILL_REL;
          end
        end
        S_FILL_REL: if (!mem_ack) state <= S_RESPOND;
        S_RESPOND: begin
          cpu_ack <= 1'b1;
          state <= S_RELEASE;
        end
        S_RELEASE: begin
          if (!cpu_req) begin
            cpu_ack <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // address and data registers, only changed while mem_req is low
  always_ff @(posedge clk) begin
    if (state == S_IDLE && cpu_req) addr_q <= cpu_addr;
    if (state == S_LOOKUP) begin
      way_q <= cur_way;
      mem_wdata <= rline.word;
      mem_addr <= tag.way_dirty ? wb_addr.word : fill_addr.word;
    end
    if (state == S_WB_REL) mem_addr <= fill_addr.word;
    if (state == S_RESPOND) begin
      cpu_rdata <= cpu_we ? cpu_wdata : rline.bytes[addr_q.f.offset];
    end
  end

endmodule

/* design/cache_l1_top.sv */
`include "cache_consts.svh"

module cache_l1_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cpu_req,
  input  logic                     cpu_we,
  input  logic [`CACHE_ADDR_W-1:0] cpu_addr,
  input  logic [7:0]               cpu_wdata,
  output logic                     cpu_ack,
  output logic [7:0]               cpu_rdata,
  output logic                     mem_req,
  output logic                     mem_we,
  output logic [`CACHE_ADDR_W-1:0] mem_addr,
  output logic [`CACHE_LINE_W-1:0] mem_wdata,
  input  logic                     mem_ack,
  input  logic [`CACHE_LINE_W-1:0] mem_rdata
);

  tag_if  tag_bus ();
  use_if  use_bus ();
  data_if data_bus ();

  cache_ctrl_fsm cache_ctrl_fsm_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .tag       (tag_bus),
    .usage     (use_bus),
    .data      (data_bus)
  );

  tag_store tag_store_inst (
    .clk   (clk),
    .reset (reset),
    .tag   (tag_bus)
  );

  use_counters use_counters_inst (
    .clk   (clk),
    .reset (reset),
    .usage (use_bus)
  );

  data_store data_store_inst (
    .clk  (clk),
    .data (data_bus)
  );

endmodule

/* tb/tb_clock.sv */
module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // period 8
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk) reset = 1'b0;  // away from the sampling edge
  end

endmodule

/* tb/cache_tb.sv */
`include "cache_consts.svh"

module cache_tb;

  logic                     clk;
  logic                     reset;
  logic                     cpu_req;
  logic                     cpu_we;
  logic [`CACHE_ADDR_W-1:0] cpu_addr;
  logic [7:0]               cpu_wdata;
  logic                     cpu_ack;
  logic [7:0]               cpu_rdata;
  logic                     mem_req;
  logic                     mem_we;
  logic [`CACHE_ADDR_W-1:0] mem_addr;
  logic [`CACHE_LINE_W-1:0] mem_wdata;
  logic                     mem_ack;
  logic [`CACHE_LINE_W-1:0] mem_rdata;

  logic [7:0]               shadow [logic [`CACHE_ADDR_W-1:0]];     // every cpu write
  logic [`CACHE_LINE_W-1:0] mem_lines [logic [`CACHE_ADDR_W-1:0]];  // lines written back
  logic [15:0]              lfsr_q = 16'd23215;
  logic                     hung = 1'b0;
  int                       checks = 0;
  int                       errors = 0;
  int                       err_mark = 0;
  int                       mem_reads = 0;
  int                       mem_writes = 0;
  logic [`CACHE_ADDR_W-1:0] last_rd_addr;
  logic [`CACHE_ADDR_W-1:0] last_wr_addr;

  tb_clock tb_clock_inst (.clk(clk), .reset(reset));

  cache_l1_top cache_l1_top_inst (
    .clk       (clk),
    .reset     (reset),
    .cpu_req   (cpu_req),
    .cpu_we    (cpu_we),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ack   (cpu_ack),
    .cpu_rdata (cpu_rdata),
    .mem_req   (mem_req),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

  mem_req_rise: assert property (@(posedge clk) disable iff (reset)
      $rose(mem_req) |-> !$past(mem_ack))
    else begin
      $display("%0t: mem_req rose while mem_ack was still high", $time);
      errors++;
    end

  mem_hold: assert property (@(posedge clk) disable iff (reset)
      (mem_req && $past(mem_req)) |-> ($stable(mem_addr) && $stable(mem_wdata)))
    else begin
      $display("%0t: mem_addr or mem_wdata changed while mem_req was high", $time);
      errors++;
    end

  ack_hold: assert property (@(posedge clk) disable iff (reset)
      (cpu_ack && cpu_req) |=> cpu_ack)
    else begin
      $display("%0t: cpu_ack fell while cpu_req was still high", $time);
      errors++;
    end

  ack_drop: assert property (@(posedge clk) disable iff (reset)
      (cpu_ack && !cpu_req) |=> !cpu_ack)
    else begin
      $display("%0t: cpu_ack stayed high after cpu_req fell", $time);
      errors++;
    end

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[6:0], lfsr_bit()};
    return v;
  endfunction

  // initial memory content, a scramble of the whole line address
  function automatic logic [`CACHE_LINE_W-1:0] line_hash(input logic [`CACHE_ADDR_W-1:0] la);
    logic [31:0] x;
    x = {8'hc5, la} ^ 32'h2f6b_91d3;
    for (int i = 0; i < 32; i++) x = {x[30:0], x[31] ^ x[21] ^ x[1] ^ x[0]};
    return x;
  endfunction

  function automatic logic [7:0] expect_byte(input logic [`CACHE_ADDR_W-1:0] addr);
    line_pkg::cache_line_u l;
    if (shadow.exists(addr)) return shadow[addr];
    l.word = line_hash({addr[`CACHE_ADDR_W-1:2], 2'b00});
    return l.bytes[addr[1:0]];
  endfunction

  function automatic logic [`CACHE_LINE_W-1:0] expect_line(input logic [`CACHE_ADDR_W-1:0] la);
    line_pkg::cache_line_u l;
    for (int b = 0; b < 4; b++) l.bytes[b] = expect_byte({la[`CACHE_ADDR_W-1:2], 2'(b)});
    return l.word;
  endfunction

  function automatic logic [`CACHE_ADDR_W-1:0] addr_of(input logic [`CACHE_TAG_W-1:0] tag,
      input logic [`CACHE_INDEX_W-1:0] index, input logic [`CACHE_OFFSET_W-1:0] offset);
    addr_pkg::cache_addr_u a;
    a.f.tag = tag;
    a.f.index = index;
    a.f.offset = offset;
    return a.word;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    assert (got === exp)
    else begin
      $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
      errors++;
    end
  endtask

  task automatic close_test(input int num, input string name);
    $display("test %0d %s: %0d errors", num, name, errors - err_mark);
    err_mark = errors;
  endtask

  // one four-phase cpu access, lat counts edges after the sampling edge
  task automatic access(input logic we, input logic [`CACHE_ADDR_W-1:0] addr,
      input logic [7:0] wdata, input int hold, output logic [7:0] rdata, output int lat);
    int n;
    rdata = '0;
    lat = 0;
    if (hung) return;
    cpu_req = 1'b1;
    cpu_we = we;
    cpu_addr = addr;
    cpu_wdata = wdata;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!cpu_ack && n < 200);
    if (!cpu_ack) begin
      $display("timeout: cpu_ack did not rise within 200 cycles at %0t", $time);
      hung = 1'b1;
      cpu_req = 1'b0;
      return;
    end
    lat = n - 1;
    rdata = cpu_rdata;
    repeat (hold) @(posedge clk);  // cpu keeps the request up a while
    #1;
    cpu_req = 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (cpu_ack && n < 200);
    if (cpu_ack) begin
      $display("timeout: cpu_ack did not fall within 200 cycles at %0t", $time);
      hung = 1'b1;
    end
  endtask

  task automatic write_byte(input logic [`CACHE_ADDR_W-1:0] addr, input logic [7:0] wdata,
      input int hold);
    logic [7:0] rd;
    int lat;
    access(1'b1, addr, wdata, hold, rd, lat);
    if (!hung) shadow[addr] = wdata;
  endtask

  task automatic read_check(input logic [`CACHE_ADDR_W-1:0] addr, input int hold,
      output int lat);
    logic [7:0] rd;
    access(1'b0, addr, 8'h00, hold, rd, lat);
    if (!hung) check_value("cpu_rdata", 32'(expect_byte(addr)), 32'(rd));
  endtask

  // lower memory, answers after 2 to 5 cycles
  initial begin : memory_model
    int delay;
    int n;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req && !mem_ack && !hung) begin
        delay = 2 + int'(rand_bits(2));
        repeat (delay) @(posedge clk);
        #1;
        check_value("mem_addr[1:0]", 32'd0, 32'(mem_addr[1:0]));
        if (mem_we) begin
          check_value("mem_wdata", expect_line(mem_addr), mem_wdata);
          mem_lines[mem_addr] = mem_wdata;
          mem_writes++;
          last_wr_addr = mem_addr;
        end else begin
          mem_rdata = mem_lines.exists(mem_addr) ? mem_lines[mem_addr] : line_hash(mem_addr);
          mem_reads++;
          last_rd_addr = mem_addr;
        end
        mem_ack = 1'b1;
        n = 0;
        do begin
          @(posedge clk);
          #1;
          n++;
        end while (mem_req && n < 200);
        if (mem_req) begin
          $display("timeout: mem_req stayed high for 200 cycles at %0t", $time);
          hung = 1'b1;
        end
        mem_ack = 1'b0;
      end
    end
  end

  initial begin
    int lat;
    int n;
    int r0;
    int w0;
    logic [`CACHE_ADDR_W-1:0] a;
    cpu_req = 1'b0;
    cpu_we = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (reset && n < 200);
    if (reset) begin
      $display("timeout: reset was never released");
      hung = 1'b1;
    end

    check_value("cpu_ack", 32'd0, 32'(cpu_ack));
    check_value("mem_req", 32'd0, 32'(mem_req));
    write_byte(addr_of(18'h040, 4'd1, 2'd2), 8'h3c, 0);
    read_check(addr_of(18'h040, 4'd1, 2'd2), 0, lat);
    check_value("cpu_ack latency", 32'd2, 32'(lat));
    close_test(1, "reset and hit timing");

    r0 = mem_reads;
    w0 = mem_writes;
    read_check(addr_of(18'h050, 4'd2, 2'd3), 0, lat);
    check_value("mem read count", 32'd1, 32'(mem_reads - r0));
    check_value("mem write count", 32'd0, 32'(mem_writes - w0));
    check_value("mem_addr", 32'(addr_of(18'h050, 4'd2, 2'd0)), 32'(last_rd_addr));
    close_test(2, "read miss");

    for (int t = 1; t <= 4; t++) write_byte(addr_of(18'h100 + 18'(t), 4'd5, 2'(t)),
        8'(32'ha0 + t), 0);
    for (int t = 2; t <= 4; t++) read_check(addr_of(18'h100 + 18'(t), 4'd5, 2'd0), 0, lat);
    r0 = mem_reads;
    w0 = mem_writes;
    read_check(addr_of(18'h105, 4'd5, 2'd1), 0, lat);  // tag 1 holds the lowest count
    check_value("mem write count", 32'd1, 32'(mem_writes - w0));
    check_value("mem_addr", 32'(addr_of(18'h101, 4'd5, 2'd0)), 32'(last_wr_addr));
    check_value("mem read count", 32'd1, 32'(mem_reads - r0));
    check_value("mem_addr", 32'(addr_of(18'h105, 4'd5, 2'd0)), 32'(last_rd_addr));
    close_test(3, "least-used eviction");

    for (int t = 1; t <= 4; t++) read_check(addr_of(18'h200 + 18'(t), 4'd7, 2'(t)), 0, lat);
    r0 = mem_reads;
    w0 = mem_writes;
    read_check(addr_of(18'h205, 4'd7, 2'd0), 0, lat);
    check_value("mem write count", 32'd0, 32'(mem_writes - w0));
    check_value("mem read count", 32'd1, 32'(mem_reads - r0));
    close_test(4, "clean victim");

    write_byte(addr_of(18'h060, 4'd1, 2'd1), 8'h5e, 3);  // miss with a long cpu hold
    read_check(addr_of(18'h060, 4'd1, 2'd1), 2, lat);
    close_test(5, "handshake hold");

    for (int k = 0; k < 300; k++) begin
      a = addr_of(18'h300 + 18'(rand_bits(3)), 4'd9 + 4'(rand_bits(2) % 8'd3),
          2'(rand_bits(2)));
      if (rand_bits(1) == 8'd1) begin
        write_byte(a, rand_bits(8), 0);
      end else begin
        read_check(a, 0, lat);
      end
    end
    close_test(6, "random traffic");

    $display("summary: %0d checks, %0d errors, %0d memory reads, %0d memory writes",
        checks, errors, mem_reads, mem_writes);
    if (!hung && errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+design
design/addr_pkg.sv
design/line_pkg.sv
design/array_ifs.sv
design/tag_store.sv
design/use_counters.sv
design/data_store.sv
design/cache_ctrl_fsm.sv
design/cache_l1_top.sv
tb/tb_clock.sv
tb/cache_tb.sv

/* Makefile */
TOP := cache_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; cat sim.log
	grep -qx "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
